// ==== hw/or1420CiPkg.sv ====
package or1420CiPkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Custom-instruction word types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [31:0] ciWordT;  // Operand and result word
  typedef logic [7:0]  ciIdT;    // Custom-instruction number

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Default instruction numbers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam ciIdT defaultSwapId  = 8'd1;
  localparam ciIdT defaultDelayId = 8'd6;

  // Cycles per microsecond for a slow simulation clock
  localparam int defaultCyclesPerMicrosecond = 4;

  // Delay unit FSM
  typedef enum logic {
    delayIdle,
    delayCounting
  } delayStateT;

endpackage

// ==== hw/resetStretcher.sv ====
`timescale 1ns/1ps

module resetStretcher #(
  parameter int resetCycles = 16
) (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic cpuReset
);

  localparam int countWidth = $clog2(resetCycles + 1);
  localparam logic [countWidth-1:0] finalCount = countWidth'(resetCycles);
  localparam logic [countWidth-1:0] lastBusyCount = countWidth'(resetCycles - 1);

  logic [countWidth-1:0] resetCount;

  // Saturating counter that restarts on every loss of lock
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (resetCount != finalCount) begin
      resetCount <= resetCount + 1'b1;
    end
  end

  // Registered so the units see a glitch-free reset
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      cpuReset <= 1'b1;
    end else if (resetCount == lastBusyCount) begin
      cpuReset <= 1'b0;  // Falls on the same edge the count saturates
    end
  end

endmodule

// ==== hw/swapByteUnit.sv ====
`timescale 1ns/1ps

module swapByteUnit #(
  parameter or1420CiPkg::ciIdT swapId = or1420CiPkg::defaultSwapId
) (
  input  logic                s_systemClock,
  input  logic                cpuReset,
  input  logic                ciStart,
  input  or1420CiPkg::ciIdT   ciN,
  input  or1420CiPkg::ciWordT ciDataA,
  input  or1420CiPkg::ciWordT ciDataB,
  output logic                unitDone,
  output or1420CiPkg::ciWordT unitResult
);

  import or1420CiPkg::*;

  logic   selected;
  ciWordT swappedWord;

  assign selected = ciStart && (ciN == swapId);

  always_comb begin
    if (ciDataB[0]) begin
      // Swap the bytes inside each halfword
      swappedWord = {ciDataA[23:16], ciDataA[31:24], ciDataA[7:0], ciDataA[15:8]};
    end else begin
      // Full endian reversal
      swappedWord = {ciDataA[7:0], ciDataA[15:8], ciDataA[23:16], ciDataA[31:24]};
    end
  end

  always_ff @(posedge s_systemClock or posedge cpuReset) begin
    if (cpuReset) begin
      unitDone   <= 1'b0;
      unitResult <= '0;
    end else begin
      unitDone   <= selected;
      unitResult <= selected ? swappedWord : '0;  // Zero keeps the OR merge clean
    end
  end

endmodule

// ==== hw/microDelayUnit.sv ====
`timescale 1ns/1ps

module microDelayUnit #(
  parameter or1420CiPkg::ciIdT delayId = or1420CiPkg::defaultDelayId,
  parameter int cyclesPerMicrosecond = or1420CiPkg::defaultCyclesPerMicrosecond
) (
  input  logic                s_systemClock,
  input  logic                cpuReset,
  input  logic                ciStart,
  input  or1420CiPkg::ciIdT   ciN,
  input  or1420CiPkg::ciWordT ciDataA,
  output logic                unitDone,
  output or1420CiPkg::ciWordT unitResult
);

  import or1420CiPkg::*;

  localparam int prescaleWidth = (cyclesPerMicrosecond > 1) ? $clog2(cyclesPerMicrosecond) : 1;
  localparam logic [prescaleWidth-1:0] lastPrescale =
    prescaleWidth'(cyclesPerMicrosecond - 1);

  delayStateT               delayState;
  logic [prescaleWidth-1:0] prescaleCount;
  ciWordT                   microCount;  // Microseconds left including the current one

  logic                     selected;
  logic [prescaleWidth-1:0] activePrescale;
  ciWordT                   activeMicro;
  logic                     prescaleWrap;
  logic                     lastCycle;

  assign selected = ciStart && (ciN == delayId);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Cycle accounting
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // The start cycle is counted like any other cycle of the delay
  always_comb begin
    if (delayState == delayIdle) begin
      activePrescale = '0;
      activeMicro    = ciDataA;
    end else begin
      activePrescale = prescaleCount;
      activeMicro    = microCount;
    end
  end

  assign prescaleWrap = (activePrescale == lastPrescale);
  assign lastCycle    = (activeMicro == '0) || (prescaleWrap && (activeMicro == 32'd1));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Delay FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge s_systemClock or posedge cpuReset) begin
    if (cpuReset) begin
      delayState    <= delayIdle;
      prescaleCount <= '0;
      microCount    <= '0;
      unitDone      <= 1'b0;
    end else begin
      unitDone <= 1'b0;
      case (delayState)
        delayIdle: begin
          if (selected) begin
            if (lastCycle) begin
              unitDone <= 1'b1;  // Zero or single-cycle delay
            end else begin
              delayState <= delayCounting;
            end
          end
        end
        delayCounting: begin
          if (lastCycle) begin
            unitDone   <= 1'b1;
            delayState <= delayIdle;
          end
        end
        default: delayState <= delayIdle;
      endcase

      if (prescaleWrap) begin
        prescaleCount <= '0;
        microCount    <= activeMicro - 1'b1;
      end else begin
        prescaleCount <= activePrescale + 1'b1;
        microCount    <= activeMicro;
      end
    end
  end

  assign unitResult = '0;  // A delay returns nothing

endmodule

// ==== hw/ciResponse.sv ====
`timescale 1ns/1ps

module ciResponse (
  input  logic                s_systemClock,
  input  logic                cpuReset,
  input  logic                swapDone,
  input  or1420CiPkg::ciWordT swapResult,
  input  logic                delayDone,
  input  or1420CiPkg::ciWordT delayResult,
  output logic                ciDone,
  output or1420CiPkg::ciWordT ciResult
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Response merge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Idle units drive zero, so a plain OR selects the one that answers
  always_ff @(posedge s_systemClock or posedge cpuReset) begin
    if (cpuReset) begin
      ciDone   <= 1'b0;
      ciResult <= '0;
    end else begin
      ciDone   <= swapDone | delayDone;
      ciResult <= swapResult | delayResult;
    end
  end

endmodule

// ==== hw/or1420CiSubsystem.sv ====
`timescale 1ns/1ps

module or1420CiSubsystem #(
  parameter or1420CiPkg::ciIdT swapId  = or1420CiPkg::defaultSwapId,
  parameter or1420CiPkg::ciIdT delayId = or1420CiPkg::defaultDelayId,
  parameter int cyclesPerMicrosecond   = or1420CiPkg::defaultCyclesPerMicrosecond,
  parameter int resetCycles            = 16
) (
  input  logic                s_systemClock,
  input  logic                s_pllLocked,
  input  logic                ciStart,
  input  or1420CiPkg::ciIdT   ciN,
  input  or1420CiPkg::ciWordT ciDataA,
  input  or1420CiPkg::ciWordT ciDataB,
  output logic                cpuReset,
  output logic                ciDone,
  output or1420CiPkg::ciWordT ciResult
);

  import or1420CiPkg::*;

  logic   swapDone;
  ciWordT swapResult;
  logic   delayDone;
  ciWordT delayResult;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reset after PLL lock
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  resetStretcher #(
    .resetCycles(resetCycles)
  ) u_resetStretcher (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .cpuReset     (cpuReset)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Custom-instruction units
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  swapByteUnit #(
    .swapId(swapId)
  ) u_swapByteUnit (
    .s_systemClock(s_systemClock),
    .cpuReset     (cpuReset),
    .ciStart      (ciStart),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .ciDataB      (ciDataB),
    .unitDone     (swapDone),
    .unitResult   (swapResult)
  );

  microDelayUnit #(
    .delayId             (delayId),
    .cyclesPerMicrosecond(cyclesPerMicrosecond)
  ) u_microDelayUnit (
    .s_systemClock(s_systemClock),
    .cpuReset     (cpuReset),
    .ciStart      (ciStart),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .unitDone     (delayDone),
    .unitResult   (delayResult)
  );

  // Single registered answer back to the processor side
  ciResponse u_ciResponse (
    .s_systemClock(s_systemClock),
    .cpuReset     (cpuReset),
    .swapDone     (swapDone),
    .swapResult   (swapResult),
    .delayDone    (delayDone),
    .delayResult  (delayResult),
    .ciDone       (ciDone),
    .ciResult     (ciResult)
  );

endmodule

// ==== bench/ciChecker.sv ====
`timescale 1ns/1ps

module ciChecker #(
  parameter int cyclesPerMicrosecond = or1420CiPkg::defaultCyclesPerMicrosecond
) (
  input  logic                s_systemClock,
  input  logic                cpuReset,
  input  logic                ciStart,
  input  or1420CiPkg::ciIdT   ciN,
  input  or1420CiPkg::ciWordT ciDataA,
  input  or1420CiPkg::ciWordT ciDataB,
  input  logic                ciDone,
  input  or1420CiPkg::ciWordT ciResult,
  output int                  errorCount,
  output int                  checkCount,
  output int                  pendingCount
);

  import or1420CiPkg::*;

  int     cycle;
  int     dueQ[$];     // Cycle in which ciDone is expected
  ciWordT resultQ[$];

  // Reference model of both instructions
  function automatic ciWordT expectedResult(ciIdT n, ciWordT a, ciWordT b);
    ciWordT r;
    int     i;
    r = '0;
    if (n == defaultSwapId) begin
      for (i = 0; i < 4; i++) begin
        if (b[0]) begin
          r[8*i +: 8] = a[8*(i ^ 1) +: 8];  // Neighbour byte in the same half
        end else begin
          r[8*i +: 8] = a[8*(3 - i) +: 8];
        end
      end
    end
    return r;
  endfunction

  // Start to ciDone as seen at the ports
  function automatic int expectedLatency(ciIdT n, ciWordT a);
    int latency;
    latency = 2;
    if (n == defaultDelayId && int'(a) * cyclesPerMicrosecond + 1 > 2) begin
      latency = int'(a) * cyclesPerMicrosecond + 1;
    end
    return latency;
  endfunction

  task automatic reportValue(input string name, input ciWordT expected, input ciWordT actual);
    $display("** Error at %0t: %s expected %h, actual %h", $time, name, expected, actual);
    errorCount++;
  endtask

  initial begin
    cycle        = 0;
    errorCount   = 0;
    checkCount   = 0;
    pendingCount = 0;
  end

  always @(posedge s_systemClock) begin
    cycle = cycle + 1;
    if (cpuReset) begin
      if (ciDone !== 1'b0) begin
        reportValue("ciDone", 32'd0, {31'd0, ciDone});
      end
      dueQ.delete();     // Nothing in flight survives a reset
      resultQ.delete();
    end else begin
      if (dueQ.size() > 0 && dueQ[0] == cycle) begin
        checkCount++;
        if (ciDone !== 1'b1) begin
          reportValue("ciDone", 32'd1, {31'd0, ciDone});
        end else if (ciResult !== resultQ[0]) begin
          reportValue("ciResult", resultQ[0], ciResult);
        end
        void'(dueQ.pop_front());
        void'(resultQ.pop_front());
      end else if (ciDone !== 1'b0) begin
        reportValue("ciDone", 32'd0, {31'd0, ciDone});
      end
      if (ciStart && (ciN == defaultSwapId || ciN == defaultDelayId)) begin
        dueQ.push_back(cycle + expectedLatency(ciN, ciDataA));
        resultQ.push_back(expectedResult(ciN, ciDataA, ciDataB));
      end
    end
    pendingCount = dueQ.size();
  end

endmodule

// ==== bench/or1420CiSubsystem_props.sv ====
`timescale 1ns/1ps

module or1420CiSubsystemProps #(
  parameter or1420CiPkg::ciIdT delayId = or1420CiPkg::defaultDelayId
) (
  input logic                    s_systemClock,
  input logic                    cpuReset,
  input logic                    ciStart,
  input or1420CiPkg::ciIdT       ciN,
  input logic                    ciDone,
  input or1420CiPkg::ciWordT     ciResult,
  input or1420CiPkg::delayStateT delayState
);

  import or1420CiPkg::*;

  doneQuietInReset: assert property (@(posedge s_systemClock) cpuReset |-> !ciDone)
    else $error("ciDone high while cpuReset is active");

  resultZeroWhenIdle: assert property (@(posedge s_systemClock) !ciDone |-> ciResult == '0)
    else $error("ciResult nonzero without ciDone");

  // A second delay start would be lost without a handshake
  noDelayRestart: assert property (@(posedge s_systemClock)
    delayState == delayCounting |-> !(ciStart && ciN == delayId))
    else $error("delay start while a delay is counting");

endmodule

bind or1420CiSubsystem or1420CiSubsystemProps #(
  .delayId(delayId)
) u_props (
  .s_systemClock(s_systemClock),
  .cpuReset     (cpuReset),
  .ciStart      (ciStart),
  .ciN          (ciN),
  .ciDone       (ciDone),
  .ciResult     (ciResult),
  .delayState   (u_microDelayUnit.delayState)
);

// ==== bench/or1420CiSubsystemTb.sv ====
`timescale 1ns/1ps

module or1420CiSubsystemTb;

  import or1420CiPkg::*;

  localparam int cyclesPerMicrosecond = defaultCyclesPerMicrosecond;
  localparam int resetCycles          = 16;
  localparam int waitLimit            = 400;
  localparam ciIdT unknownId          = 8'hA5;

  logic   s_systemClock;
  logic   s_pllLocked;
  logic   ciStart;
  ciIdT   ciN;
  ciWordT ciDataA;
  ciWordT ciDataB;
  logic   cpuReset;
  logic   ciDone;
  ciWordT ciResult;

  int          checkerErrors;
  int          checkCount;
  int          pendingCount;
  int          benchErrors;
  bit          timedOut;
  logic [31:0] randState;

  or1420CiSubsystem #(
    .swapId              (defaultSwapId),
    .delayId             (defaultDelayId),
    .cyclesPerMicrosecond(cyclesPerMicrosecond),
    .resetCycles         (resetCycles)
  ) u_dut (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .ciStart      (ciStart),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .ciDataB      (ciDataB),
    .cpuReset     (cpuReset),
    .ciDone       (ciDone),
    .ciResult     (ciResult)
  );

  ciChecker #(
    .cyclesPerMicrosecond(cyclesPerMicrosecond)
  ) u_checker (
    .s_systemClock(s_systemClock),
    .cpuReset     (cpuReset),
    .ciStart      (ciStart),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .ciDataB      (ciDataB),
    .ciDone       (ciDone),
    .ciResult     (ciResult),
    .errorCount   (checkerErrors),
    .checkCount   (checkCount),
    .pendingCount (pendingCount)
  );

  always #20 s_systemClock = ~s_systemClock;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] nextRandom();
    randState = xorshift32(randState);
    return randState;
  endfunction

  task automatic startCi(input ciIdT n, input ciWordT a, input ciWordT b);
    @(posedge s_systemClock);
    ciStart <= 1'b1;
    ciN     <= n;
    ciDataA <= a;
    ciDataB <= b;
  endtask

  task automatic endStart();
    @(posedge s_systemClock);
    ciStart <= 1'b0;
    ciN     <= '0;
  endtask

  task automatic waitIdle(input string what);
    int i;
    for (i = 0; i < waitLimit && !timedOut; i++) begin
      @(negedge s_systemClock);
      if (pendingCount == 0) begin
        break;
      end
    end
    if (!timedOut && pendingCount != 0) begin
      $display("Timeout: %s still waits for %0d answers", what, pendingCount);
      timedOut = 1'b1;
    end
  endtask

  task automatic expectNoDone(input int cycles);
    int i;
    for (i = 0; i < cycles; i++) begin
      @(negedge s_systemClock);
      if (ciDone !== 1'b0) begin
        $display("** Error at %0t: ciDone expected 0, actual %b", $time, ciDone);
        benchErrors++;
      end
    end
  endtask

  // Locks the PLL and counts edges until cpuReset falls
  task automatic releaseReset();
    int edges;
    int i;
    edges = 0;
    @(posedge s_systemClock);
    s_pllLocked <= 1'b1;
    for (i = 0; i < waitLimit; i++) begin
      @(posedge s_systemClock);
      edges++;
      @(negedge s_systemClock);
      if (!cpuReset) begin
        break;
      end
    end
    if (cpuReset) begin
      $display("Timeout: cpuReset never fell after the PLL locked");
      timedOut = 1'b1;
    end else if (edges != resetCycles) begin
      $display("** Error at %0t: cpuReset edges expected %0d, actual %0d",
               $time, resetCycles, edges);
      benchErrors++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    int     i;
    ciWordT a;
    ciWordT b;
    ciWordT r;
    s_systemClock = 1'b0;
    s_pllLocked   = 1'b0;
    ciStart       = 1'b0;
    ciN           = '0;
    ciDataA       = '0;
    ciDataB       = '0;
    benchErrors   = 0;
    timedOut      = 1'b0;
    randState     = 32'h560;

    repeat (3) @(posedge s_systemClock);
    releaseReset();

    for (i = 0; i < 20; i++) begin  // Single swaps in alternating modes
      a    = nextRandom();
      b    = nextRandom();
      b[0] = i[0];
      startCi(defaultSwapId, a, b);
      endStart();
      waitIdle("single swap");
    end

    for (i = 0; i < 16; i++) begin  // Back to back
      a = nextRandom();
      b = nextRandom();
      startCi(defaultSwapId, a, b);
    end
    endStart();
    waitIdle("swap burst");

    for (i = 0; i < 6; i++) begin
      r = nextRandom();
      if (i < 2) begin
        a = i;
      end else begin
        a = {29'd0, r[2:0]} + 32'd2;
      end
      startCi(defaultDelayId, a, nextRandom());
      endStart();
      waitIdle("delay");
    end

    startCi(unknownId, nextRandom(), nextRandom());
    endStart();
    expectNoDone(50);
    startCi(defaultSwapId, nextRandom(), 32'd1);
    endStart();
    waitIdle("swap after unknown number");

    // Lock lost while a delay is counting
    startCi(defaultDelayId, 32'd8, 32'd0);
    endStart();
    repeat (6) @(negedge s_systemClock);
    @(posedge s_systemClock);
    s_pllLocked <= 1'b0;
    @(negedge s_systemClock);
    if (cpuReset !== 1'b1) begin
      $display("** Error at %0t: cpuReset expected 1, actual %b", $time, cpuReset);
      benchErrors++;
    end
    expectNoDone(2);
    releaseReset();
    expectNoDone(40);
    for (i = 0; i < 8; i++) begin
      a = nextRandom();
      b = nextRandom();
      startCi(defaultSwapId, a, b);
    end
    endStart();
    waitIdle("swaps after relock");

    repeat (4) @(posedge s_systemClock);
    $display("Summary: %0d checks, %0d checker errors, %0d bench errors, %0d timeouts",
             checkCount, checkerErrors, benchErrors, timedOut);
    if (!timedOut && checkerErrors == 0 && benchErrors == 0 && checkCount > 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
hw/or1420CiPkg.sv
hw/resetStretcher.sv
hw/swapByteUnit.sv
hw/microDelayUnit.sv
hw/ciResponse.sv
hw/or1420CiSubsystem.sv
bench/ciChecker.sv
bench/or1420CiSubsystem_props.sv
bench/or1420CiSubsystemTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the custom-instruction testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log
topModule=or1420CiSubsystemTb

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$topModule" --Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/V"$topModule" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "^all tests passed$" "$logFile"; then
  echo "Result: PASS"
  exit 0
fi
echo "Result: FAIL"
exit 1
